/* design/tcb_defs.svh */
// TCB bus subsystem shared sizes
// bus widths, memory depth and response delays used by every block

`ifndef TCB_DEFS_SVH
`define TCB_DEFS_SVH

// byte address width
`define TCB_ADR_W 12
// data width in bits
`define TCB_DAT_W 32
// number of byte lanes
`define TCB_BYT_W 4

// memory depth in words, covers byte addresses 0 to 1023
`define TCB_MEM_WORDS 256

// memory read delay in cycles
`define TCB_MEM_DLY 1
// delay seen by a manager, memory plus the request slice
`define TCB_RSP_DLY (`TCB_MEM_DLY + 1)

`endif

/* design/tcb_pkg.sv */
// TCB bus vector types
// address, data and byte enable vectors shared by all bus links

`default_nettype none

`include "tcb_defs.svh"

package tcb_pkg;

    //////////////////////////////////////////////////
    // bus field types
    //////////////////////////////////////////////////

    // byte address
    typedef logic [`TCB_ADR_W-1:0] adr_t;

    // data word, write and read data
    typedef logic [`TCB_DAT_W-1:0] dat_t;

    // byte enables, one bit per lane
    typedef logic [`TCB_BYT_W-1:0] byt_t;

endpackage : tcb_pkg

`default_nettype wire

/* design/tcb_register_request.sv */
// TCB register slice for the request path
// cuts the request path with one register stage, response passes through

`timescale 1ns/1ns
`default_nettype none

`include "tcb_defs.svh"

module tcb_register_request (
    input  wire logic          sub,
    input  wire logic          rst_n,
    // subordinate side, a manager connects here
    input  wire logic          sub_vld,
    input  wire logic          sub_wen,
    input  wire tcb_pkg::adr_t sub_adr,
    input  wire tcb_pkg::byt_t sub_byt,
    input  wire tcb_pkg::dat_t sub_wdt,
    output logic               sub_rdy,
    output tcb_pkg::dat_t      sub_rdt,
    output logic               sub_err,
    // manager side, a subordinate connects here
    output logic               man_vld,
    output logic               man_wen,
    output tcb_pkg::adr_t      man_adr,
    output tcb_pkg::byt_t      man_byt,
    output tcb_pkg::dat_t      man_wdt,
    input  wire logic          man_rdy,
    input  wire tcb_pkg::dat_t man_rdt,
    input  wire logic          man_err
);

    import tcb_pkg::*;

    //////////////////////////////////////////////////
    // request register
    //////////////////////////////////////////////////

    // valid, loaded whenever the sub side can take a new request
    always_ff @(posedge sub) begin
        if (!rst_n) begin
            man_vld <= 1'b0;
        end else if (sub_rdy) begin
            man_vld <= sub_vld;
        end
    end

    // payload, held while the man side stalls
    always_ff @(posedge sub) begin
        if (sub_rdy) begin
            man_wen <= sub_wen;
            man_adr <= sub_adr;
            man_byt <= sub_byt;
            // only enabled write lanes toggle
            if (sub_wen) begin
                for (int i = 0; i < `TCB_BYT_W; i++) begin
                    if (sub_byt[i]) begin
                        man_wdt[i*8+:8] <= sub_wdt[i*8+:8];
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // response and handshake
    //////////////////////////////////////////////////

    // response is not registered here
    assign sub_rdt = man_rdt;
    assign sub_err = man_err;

    // an empty stage can always take a request, so no bubbles
    assign sub_rdy = man_rdy | ~man_vld;

endmodule : tcb_register_request

`default_nettype wire

/* design/tcb_arbiter.sv */
// TCB round-robin arbiter for two managers
// muxes the winning request onto one shared link and steers each
// delayed response back to the manager that issued it

`timescale 1ns/1ns
`default_nettype none

`include "tcb_defs.svh"

module tcb_arbiter (
    input  wire logic          sub,
    input  wire logic          rst_n,
    // manager 0
    input  wire logic          m0_vld,
    input  wire logic          m0_wen,
    input  wire tcb_pkg::adr_t m0_adr,
    input  wire tcb_pkg::byt_t m0_byt,
    input  wire tcb_pkg::dat_t m0_wdt,
    output logic               m0_rdy,
    output tcb_pkg::dat_t      m0_rdt,
    output logic               m0_err,
    // manager 1
    input  wire logic          m1_vld,
    input  wire logic          m1_wen,
    input  wire tcb_pkg::adr_t m1_adr,
    input  wire tcb_pkg::byt_t m1_byt,
    input  wire tcb_pkg::dat_t m1_wdt,
    output logic               m1_rdy,
    output tcb_pkg::dat_t      m1_rdt,
    output logic               m1_err,
    // shared link toward the subordinate
    output logic               s_vld,
    output logic               s_wen,
    output tcb_pkg::adr_t      s_adr,
    output tcb_pkg::byt_t      s_byt,
    output tcb_pkg::dat_t      s_wdt,
    input  wire logic          s_rdy,
    input  wire tcb_pkg::dat_t s_rdt,
    input  wire logic          s_err
);

    import tcb_pkg::*;

    // last winner, 1 means m1 won the previous transfer
    logic       last;
    // combinational grants
    logic       gnt0;
    logic       gnt1;
    // owner of each transfer in flight, one-hot {m1, m0}
    logic [1:0] own [`TCB_RSP_DLY];

    //////////////////////////////////////////////////
    // grant and request mux
    //////////////////////////////////////////////////

    // m1 wins when alone or when m0 had the last turn
    assign gnt1 = m1_vld & (~m0_vld | ~last);
    assign gnt0 = m0_vld & ~gnt1;

    assign s_vld = m0_vld | m1_vld;
    assign s_wen = gnt1 ? m1_wen : m0_wen;
    assign s_adr = gnt1 ? m1_adr : m0_adr;
    assign s_byt = gnt1 ? m1_byt : m0_byt;
    assign s_wdt = gnt1 ? m1_wdt : m0_wdt;

    // the loser sees rdy low
    assign m0_rdy = s_rdy & ~gnt1;
    assign m1_rdy = s_rdy & ~gnt0;

    // reset value makes m0 win the first contest
    always_ff @(posedge sub) begin
        if (!rst_n) begin
            last <= 1'b1;
        end else if (s_vld & s_rdy) begin
            last <= gnt1;
        end
    end

    //////////////////////////////////////////////////
    // owner tracking and response routing
    //////////////////////////////////////////////////

    // one stage per cycle of response delay
    always_ff @(posedge sub) begin
        if (!rst_n) begin
            for (int i = 0; i < `TCB_RSP_DLY; i++) begin
                own[i] <= 2'b00;
            end
        end else begin
            own[0] <= {gnt1 & s_rdy, gnt0 & s_rdy};
            for (int i = 1; i < `TCB_RSP_DLY; i++) begin
                own[i] <= own[i-1];
            end
        end
    end

    // last stage names who gets the current response
    assign m0_rdt = own[`TCB_RSP_DLY-1][0] ? s_rdt : '0;
    assign m0_err = own[`TCB_RSP_DLY-1][0] & s_err;
    assign m1_rdt = own[`TCB_RSP_DLY-1][1] ? s_rdt : '0;
    assign m1_err = own[`TCB_RSP_DLY-1][1] & s_err;

endmodule : tcb_arbiter

`default_nettype wire

/* design/tcb_sram.sv */
// TCB SRAM subordinate
// byte-writable word memory, registered read with a fixed delay,
// error flag for addresses beyond the memory

`timescale 1ns/1ns
`default_nettype none

`include "tcb_defs.svh"

module tcb_sram (
    input  wire logic          sub,
    input  wire logic          rst_n,
    input  wire logic          vld,
    input  wire logic          wen,
    input  wire tcb_pkg::adr_t adr,
    input  wire tcb_pkg::byt_t byt,
    input  wire tcb_pkg::dat_t wdt,
    output logic               rdy,
    output tcb_pkg::dat_t      rdt,
    output logic               err
);

    import tcb_pkg::*;

    // byte offset bits and word index bits
    localparam int unsigned OFS_W = $clog2(`TCB_BYT_W);
    localparam int unsigned IDX_W = $clog2(`TCB_MEM_WORDS);

    dat_t             mem [`TCB_MEM_WORDS];
    logic [IDX_W-1:0] idx;
    // address beyond the last word
    logic             oor;
    logic             trn;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    assign idx = adr[OFS_W+:IDX_W];
    // any set bit above the index means out of range
    assign oor = |adr[`TCB_ADR_W-1:OFS_W+IDX_W];

    // never stalls
    assign rdy = 1'b1;
    assign trn = vld & rdy;

    //////////////////////////////////////////////////
    // write and read
    //////////////////////////////////////////////////

    // per lane write, skipped for out of range addresses
    always_ff @(posedge sub) begin
        if (trn & wen & ~oor) begin
            for (int i = 0; i < `TCB_BYT_W; i++) begin
                if (byt[i]) begin
                    mem[idx][i*8+:8] <= wdt[i*8+:8];
                end
            end
        end
    end

    // read returns the word as it was before this cycle's write
    always_ff @(posedge sub) begin
        if (trn) begin
            rdt <= oor ? '0 : mem[idx];
        end
    end

    always_ff @(posedge sub) begin
        if (!rst_n) begin
            err <= 1'b0;
        end else if (trn) begin
            err <= oor;
        end
    end

endmodule : tcb_sram

`default_nettype wire

/* design/tcb_subsystem.sv */
// TCB subsystem top level
// two managers share one SRAM through an arbiter and a request slice

`timescale 1ns/1ns
`default_nettype none

`include "tcb_defs.svh"

module tcb_subsystem (
    input  wire logic          sub,
    input  wire logic          rst_n,
    // manager 0
    input  wire logic          m0_vld,
    input  wire logic          m0_wen,
    input  wire tcb_pkg::adr_t m0_adr,
    input  wire tcb_pkg::byt_t m0_byt,
    input  wire tcb_pkg::dat_t m0_wdt,
    output logic               m0_rdy,
    output tcb_pkg::dat_t      m0_rdt,
    output logic               m0_err,
    // manager 1
    input  wire logic          m1_vld,
    input  wire logic          m1_wen,
    input  wire tcb_pkg::adr_t m1_adr,
    input  wire tcb_pkg::byt_t m1_byt,
    input  wire tcb_pkg::dat_t m1_wdt,
    output logic               m1_rdy,
    output tcb_pkg::dat_t      m1_rdt,
    output logic               m1_err
);

    import tcb_pkg::*;

    // arbiter to slice, delay `TCB_RSP_DLY
    logic arb_vld;
    logic arb_wen;
    adr_t arb_adr;
    byt_t arb_byt;
    dat_t arb_wdt;
    logic arb_rdy;
    dat_t arb_rdt;
    logic arb_err;

    // slice to memory, delay `TCB_MEM_DLY
    logic mem_vld;
    logic mem_wen;
    adr_t mem_adr;
    byt_t mem_byt;
    dat_t mem_wdt;
    logic mem_rdy;
    dat_t mem_rdt;
    logic mem_err;

    //////////////////////////////////////////////////
    // arbiter, slice, memory
    //////////////////////////////////////////////////

    tcb_arbiter u_arb (
        .sub    (sub),     .rst_n  (rst_n),
        .m0_vld (m0_vld),  .m0_wen (m0_wen),  .m0_adr (m0_adr),
        .m0_byt (m0_byt),  .m0_wdt (m0_wdt),  .m0_rdy (m0_rdy),
        .m0_rdt (m0_rdt),  .m0_err (m0_err),
        .m1_vld (m1_vld),  .m1_wen (m1_wen),  .m1_adr (m1_adr),
        .m1_byt (m1_byt),  .m1_wdt (m1_wdt),  .m1_rdy (m1_rdy),
        .m1_rdt (m1_rdt),  .m1_err (m1_err),
        .s_vld  (arb_vld), .s_wen  (arb_wen), .s_adr  (arb_adr),
        .s_byt  (arb_byt), .s_wdt  (arb_wdt), .s_rdy  (arb_rdy),
        .s_rdt  (arb_rdt), .s_err  (arb_err)
    );

    tcb_register_request u_reg (
        .sub     (sub),     .rst_n   (rst_n),
        .sub_vld (arb_vld), .sub_wen (arb_wen), .sub_adr (arb_adr),
        .sub_byt (arb_byt), .sub_wdt (arb_wdt), .sub_rdy (arb_rdy),
        .sub_rdt (arb_rdt), .sub_err (arb_err),
        .man_vld (mem_vld), .man_wen (mem_wen), .man_adr (mem_adr),
        .man_byt (mem_byt), .man_wdt (mem_wdt), .man_rdy (mem_rdy),
        .man_rdt (mem_rdt), .man_err (mem_err)
    );

    tcb_sram u_mem (
        .sub (sub),     .rst_n (rst_n),
        .vld (mem_vld), .wen   (mem_wen), .adr (mem_adr),
        .byt (mem_byt), .wdt   (mem_wdt), .rdy (mem_rdy),
        .rdt (mem_rdt), .err   (mem_err)
    );

endmodule : tcb_subsystem

`default_nettype wire

/* bench/tcb_subsystem_tb.sv */
// TCB subsystem testbench
// two managers drive the subsystem while a byte-array reference model predicts
// every response and concurrent assertions compare it two edges later

`timescale 1ns/1ns
`default_nettype none

`include "tcb_defs.svh"

module tcb_subsystem_tb;

    import tcb_pkg::*;

    localparam int TIMEOUT   = 50;
    localparam int N_RANDOM  = 300;
    localparam int SEED      = 47869;
    localparam int MEM_BYTES = `TCB_BYT_W * `TCB_MEM_WORDS;

    logic sub;
    logic rst_n;
    logic m0_vld;
    logic m0_wen;
    adr_t m0_adr;
    byt_t m0_byt;
    dat_t m0_wdt;
    logic m0_rdy;
    dat_t m0_rdt;
    logic m0_err;
    logic m1_vld;
    logic m1_wen;
    adr_t m1_adr;
    byt_t m1_byt;
    dat_t m1_wdt;
    logic m1_rdy;
    dat_t m1_rdt;
    logic m1_err;

    integer     seed;
    // one bit per manager set when accepted at the last rising edge
    logic [1:0] took;
    // manager number of each accepted transfer in order
    int         order [$];
    logic [7:0] ref_mem [MEM_BYTES];
    // expected responses where stage 1 is due at the current edge
    logic [1:0] e0_vld;
    logic [1:0] e0_wen;
    logic [1:0] e0_err;
    dat_t       e0_rdt [2];
    logic [1:0] e1_vld;
    logic [1:0] e1_wen;
    logic [1:0] e1_err;
    dat_t       e1_rdt [2];

    tcb_subsystem DUT (
        .sub    (sub),    .rst_n  (rst_n),
        .m0_vld (m0_vld), .m0_wen (m0_wen), .m0_adr (m0_adr),
        .m0_byt (m0_byt), .m0_wdt (m0_wdt), .m0_rdy (m0_rdy),
        .m0_rdt (m0_rdt), .m0_err (m0_err),
        .m1_vld (m1_vld), .m1_wen (m1_wen), .m1_adr (m1_adr),
        .m1_byt (m1_byt), .m1_wdt (m1_wdt), .m1_rdy (m1_rdy),
        .m1_rdt (m1_rdt), .m1_err (m1_err)
    );

    // 10 ns clock
    always #5 sub = ~sub;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic logic out_of_range(input adr_t adr);
        return int'(adr) >= MEM_BYTES;
    endfunction

    // first byte of the word with the low address bits dropped
    function automatic int word_base(input adr_t adr);
        return (int'(adr) / `TCB_BYT_W) * `TCB_BYT_W;
    endfunction

    function automatic dat_t model_word(input adr_t adr);
        dat_t w;
        for (int i = 0; i < `TCB_BYT_W; i++) begin
            w[i*8+:8] = ref_mem[word_base(adr) + i];
        end
        return w;
    endfunction

    // zero read data for an address beyond the memory
    function automatic dat_t read_value(input adr_t adr);
        return out_of_range(adr) ? '0 : model_word(adr);
    endfunction

    task automatic model_write(input adr_t adr, input byt_t byt, input dat_t wdt);
        for (int i = 0; i < `TCB_BYT_W; i++) begin
            if (byt[i]) begin
                ref_mem[word_base(adr) + i] = wdt[i*8+:8];
            end
        end
    endtask

    // preload pattern in which every bit of the word index shows up
    function automatic dat_t fill_word(input int i);
        logic [7:0] b;
        b = 8'(i);
        return {b ^ 8'ha5, b + 8'h31, ~b, {b[3:0], b[7:4]}};
    endfunction

    //////////////////////////////////////////////////
    // monitor and response checks
    //////////////////////////////////////////////////

    // inputs only change on the falling edge so values here are pre-edge
    always @(posedge sub) begin
        if (!rst_n) begin
            took = 2'b00;
            e0_vld <= 2'b00;
            e1_vld <= 2'b00;
        end else begin
            took[0] = m0_vld & m0_rdy;
            took[1] = m1_vld & m1_rdy;
            if (took[0]) begin
                order.push_back(0);
                if (m0_wen && !out_of_range(m0_adr)) begin
                    model_write(m0_adr, m0_byt, m0_wdt);
                end
            end
            if (took[1]) begin
                order.push_back(1);
                if (m1_wen && !out_of_range(m1_adr)) begin
                    model_write(m1_adr, m1_byt, m1_wdt);
                end
            end
            e0_vld <= {e0_vld[0], took[0]};
            e0_wen <= {e0_wen[0], m0_wen};
            e0_err <= {e0_err[0], out_of_range(m0_adr)};
            e0_rdt[0] <= read_value(m0_adr);
            e0_rdt[1] <= e0_rdt[0];
            e1_vld <= {e1_vld[0], took[1]};
            e1_wen <= {e1_wen[0], m1_wen};
            e1_err <= {e1_err[0], out_of_range(m1_adr)};
            e1_rdt[0] <= read_value(m1_adr);
            e1_rdt[1] <= e1_rdt[0];
        end
    end

    // a port with no response due must show zero data and no error
    function automatic logic rsp_ok(input logic vld, input logic wen, input logic err_exp,
                                    input dat_t rdt_exp, input logic err, input dat_t rdt);
        if (!vld) begin
            return !err && rdt == '0;
        end
        if (err != err_exp) begin
            return 1'b0;
        end
        // rdt is undefined for a write
        return wen || rdt == rdt_exp;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    m0_rsp_check: assert property (@(posedge sub) disable iff (!rst_n)
        rsp_ok(e0_vld[1], e0_wen[1], e0_err[1], e0_rdt[1], m0_err, m0_rdt))
    else fail_run($sformatf("Error at %0t ns: m0 response rdt %h err %b is wrong",
                            $time, $sampled(m0_rdt), $sampled(m0_err)));

    m1_rsp_check: assert property (@(posedge sub) disable iff (!rst_n)
        rsp_ok(e1_vld[1], e1_wen[1], e1_err[1], e1_rdt[1], m1_err, m1_rdt))
    else fail_run($sformatf("Error at %0t ns: m1 response rdt %h err %b is wrong",
                            $time, $sampled(m1_rdt), $sampled(m1_err)));

    //////////////////////////////////////////////////
    // stimulus tasks that start and end on a falling edge
    //////////////////////////////////////////////////

    task automatic drive(input int m, input logic vld, input logic wen, input adr_t adr,
                         input byt_t byt, input dat_t wdt);
        if (m == 0) begin
            m0_vld = vld;
            m0_wen = wen;
            m0_adr = adr;
            m0_byt = byt;
            m0_wdt = wdt;
        end else begin
            m1_vld = vld;
            m1_wen = wen;
            m1_adr = adr;
            m1_byt = byt;
            m1_wdt = wdt;
        end
    endtask

    // request is held until accepted and waits counts the cycles it took
    task automatic transfer(input int m, input logic wen, input adr_t adr, input byt_t byt,
                            input dat_t wdt, output int waits);
        drive(m, 1'b1, wen, adr, byt, wdt);
        waits = 0;
        do begin
            @(negedge sub);
            waits++;
            if (!took[m] && waits >= TIMEOUT) begin
                fail_run($sformatf("manager m%0d stalled with rdy low for %0d cycles",
                                   m, waits));
            end
        end while (!took[m]);
        drive(m, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(negedge sub);
        rst_n = 1'b1;
    endtask

    // mixed reads and writes mostly in range with random idle gaps
    task automatic random_traffic(input int m);
        int   gap;
        int   r;
        int   w;
        adr_t adr;
        for (int i = 0; i < N_RANDOM; i++) begin
            gap = $random(seed) & 3;
            repeat (gap) @(negedge sub);
            r = $random(seed);
            adr = (r[3:0] == 4'h0) ? adr_t'(r >> 4) : {2'b00, 10'(r >> 4)};
            transfer(m, 1'($random(seed)), adr, byt_t'($random(seed)),
                     dat_t'($random(seed)), w);
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        int w;
        seed = SEED;
        sub = 1'b0;
        drive(0, 1'b0, 1'b0, '0, '0, '0);
        drive(1, 1'b0, 1'b0, '0, '0, '0);
        apply_reset();

        // preload every word so no read returns unknown data
        for (int i = 0; i < `TCB_MEM_WORDS; i++) begin
            transfer(0, 1'b1, adr_t'(i * `TCB_BYT_W), '1, fill_word(i), w);
        end

        // write then read back on m0
        transfer(0, 1'b1, 12'h010, '1, 32'h1234_5678, w);
        transfer(0, 1'b0, 12'h010, '0, '0, w);
        // read data shows between the next two rising edges
        @(negedge sub);
        assert (m0_rdt == 32'h1234_5678 && !m0_err)
        else fail_run($sformatf("Error at %0t ns: m0 read back %h err %b, expected 12345678",
                                $time, m0_rdt, m0_err));

        // lanes 1 and 3 overwritten while 0 and 2 keep their bytes
        transfer(1, 1'b1, 12'h020, '1, 32'h1122_3344, w);
        transfer(1, 1'b1, 12'h020, 4'b1010, 32'haabb_ccdd, w);
        transfer(1, 1'b0, 12'h020, '0, '0, w);
        @(negedge sub);
        assert (m1_rdt == 32'haa22_cc44 && !m1_err)
        else fail_run($sformatf("Error at %0t ns: m1 read back %h err %b, expected aa22cc44",
                                $time, m1_rdt, m1_err));

        // out of range read and writes followed by a sweep of all words
        transfer(0, 1'b0, 12'h400, '0, '0, w);
        transfer(0, 1'b1, 12'h404, '1, 32'hdead_beef, w);
        transfer(1, 1'b1, 12'hffc, '1, 32'h0bad_f00d, w);
        for (int i = 0; i < `TCB_MEM_WORDS; i++) begin
            transfer(0, 1'b0, adr_t'(i * `TCB_BYT_W), '0, '0, w);
        end

        // fresh reset so m0 wins the first contest
        repeat (3) @(negedge sub);
        apply_reset();
        order.delete();
        fork
            for (int i = 0; i < 4; i++) begin
                transfer(0, 1'b0, adr_t'(i * 4), '0, '0, w);
            end
            for (int i = 0; i < 4; i++) begin
                transfer(1, 1'b0, adr_t'((i % 2 == 1 ? 12'h400 : 12'h100) + i * 4),
                         '0, '0, w);
            end
        join
        for (int i = 0; i < 8; i++) begin
            assert (order[i] == i % 2)
            else fail_run($sformatf("Error at %0t ns: transfer %0d went to m%0d",
                                    $time, i, order[i]));
        end

        // eight back to back reads accepted one per cycle
        for (int i = 0; i < 8; i++) begin
            transfer(0, 1'b0, adr_t'(12'h040 + i * 4), '0, '0, w);
            assert (w == 1)
            else fail_run($sformatf("Error at %0t ns: m0 stalled %0d cycles", $time, w));
        end

        fork
            random_traffic(0);
            random_traffic(1);
        join

        // let the last responses reach the checks
        repeat (4) @(negedge sub);
        $display("No errors");
        $finish;
    end

endmodule : tcb_subsystem_tb

`default_nettype wire

/* project.f */
+incdir+design
design/tcb_pkg.sv
design/tcb_register_request.sv
design/tcb_arbiter.sv
design/tcb_sram.sv
design/tcb_subsystem.sv
bench/tcb_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it
# the log decides pass or fail

set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tcb_subsystem_tb \
    -f project.f \
    -o tcb_subsystem_sim

# a failing run still leaves its log for the search below
./obj_dir/tcb_subsystem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
